//--- flist.f
hw/isaPkg.sv
hw/corePkg.sv
hw/ctrlIf.sv
hw/instrDecoder.sv
hw/immGen.sv
hw/regFile.sv
hw/aluStage.sv
hw/pcUnit.sv
hw/riscvCore.sv
tb/coreTb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module coreTb -f flist.f -o coreSim

./obj_dir/coreSim > sim.log
cat sim.log

# pass only when the testbench reported it
grep -q "All checks passed" sim.log

//--- tb/coreTb.sv
`timescale 1ns/1ps

module coreTb;
    import isaPkg::*;
    import corePkg::*;

    localparam int memWords = 256;
    localparam int runLimit = 2000; // cycles allowed per program
    localparam addrT startAddr = 32'h0000_0000;

    logic  clk;
    logic  reset;
    addrT  pc;
    instrT instr;
    logic  memWe;
    addrT  memAddr;
    wordT  memWdata;
    wordT  memRdata;

    instrT instrMem [memWords];
    wordT  dataMem [memWords];
    addrT  storeAddrQ [$];
    wordT  storeDataQ [$];
    addrT  expAddrQ [$];
    wordT  expDataQ [$];
    int    progIdx;
    int    resetStores;
    int    errors;

    riscvCore #(
        .resetAddr (startAddr)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .pc       (pc),
        .instr    (instr),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    // both memories answer in the same cycle
    assign instr    = instrMem[pc[9:2]];
    assign memRdata = dataMem[memAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (memWe === 1'b1) begin
            dataMem[memAddr[9:2]] <= memWdata;
            if (reset) begin
                resetStores++;
            end else begin
                storeAddrQ.push_back(memAddr);
                storeDataQ.push_back(memWdata);
            end
        end
    end

    function automatic instrT rOp(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic instrT iOp(int op, int f3, int rd, int rs1, wordT imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic instrT addi(int rd, int rs1, wordT imm);
        return iOp(7'b0010011, 0, rd, rs1, imm);
    endfunction

    function automatic instrT lw(int rd, int rs1, wordT imm);
        return iOp(7'b0000011, 2, rd, rs1, imm);
    endfunction

    function automatic instrT jalr(int rd, int rs1, wordT imm);
        return iOp(7'b1100111, 0, rd, rs1, imm);
    endfunction

    function automatic instrT sw(int rs2, int rs1, wordT off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic instrT branch(int f3, int rs1, int rs2, wordT off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic instrT jal(int rd, wordT off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic instrT lui(int rd, wordT upper);
        return {upper[31:12], rd[4:0], 7'b0110111};
    endfunction

    function automatic instrT auipc(int rd, wordT upper);
        return {upper[31:12], rd[4:0], 7'b0010111};
    endfunction

    function automatic addrT curAddr();
        return addrT'(progIdx * 4);
    endfunction

    task automatic checkWord(string name, wordT expected, wordT actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkAddr(string name, addrT expected, addrT actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic emit(instrT word);
        instrMem[progIdx] = word;
        progIdx++;
    endtask

    task automatic emitConst(int rd, wordT value);
        emit(lui(rd, value + 32'h800)); // round up when the low part is negative
        emit(addi(rd, rd, value));
    endtask

    task automatic expectStore(addrT addr, wordT data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    task automatic startProgram();
        @(negedge clk);
        reset = 1'b1;
        resetStores = 0;
        @(negedge clk); // pc is at startAddr now
        for (int i = 1; i < memWords; i++) begin
            instrMem[i] = addi(0, 0, 0);
        end
        progIdx = 1; // address 0 keeps its nop
        storeAddrQ.delete();
        storeDataQ.delete();
        expAddrQ.delete();
        expDataQ.delete();
    endtask

    task automatic checkStores();
        checkWord("store count", wordT'(expAddrQ.size()), wordT'(storeAddrQ.size()));
        for (int i = 0; i < expAddrQ.size() && i < storeAddrQ.size(); i++) begin
            checkAddr($sformatf("store %0d address", i), expAddrQ[i], storeAddrQ[i]);
            checkWord($sformatf("store %0d data", i), expDataQ[i], storeDataQ[i]);
        end
    endtask

    task automatic runProgram();
        addrT endAddr;
        int   cycles;
        endAddr = curAddr();
        emit(jal(0, 0)); // self-loop
        repeat (15) @(negedge clk);
        checkAddr("pc in reset", startAddr, pc);
        checkWord("stores in reset", '0, wordT'(resetStores));
        reset = 1'b0;
        cycles = 0;
        while (pc !== endAddr && cycles < runLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== endAddr) begin
            errors++;
            $display("Timeout: pc did not reach the end loop at %h in %0d cycles",
                     endAddr, runLimit);
        end
        checkStores();
    endtask

    task automatic arithOps();
        wordT a;
        wordT b;
        wordT imm;
        startProgram();
        a   = $urandom() | 32'h8000_0000; // forced negative so slt must be signed
        b   = $urandom() & 32'h7fff_ffff;
        imm = $urandom() & 32'hfff;
        emitConst(1, a);
        emitConst(2, b);
        emit(rOp(0, 0, 3, 1, 2));
        emit(sw(3, 0, 32'h100));
        emit(rOp(7'b0100000, 0, 4, 1, 2));
        emit(sw(4, 0, 32'h104));
        emit(rOp(0, 7, 5, 1, 2));
        emit(sw(5, 0, 32'h108));
        emit(rOp(0, 2, 6, 1, 2));
        emit(sw(6, 0, 32'h10c));
        emit(rOp(0, 2, 7, 2, 1));
        emit(sw(7, 0, 32'h110));
        emit(addi(8, 1, imm));
        emit(sw(8, 0, 32'h114));
        expectStore(32'h100, a + b);
        expectStore(32'h104, a - b);
        expectStore(32'h108, a & b);
        expectStore(32'h10c, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectStore(32'h110, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expectStore(32'h114, a + {{20{imm[11]}}, imm[11:0]});
        runProgram();
    endtask

    task automatic loadStoreCopies();
        wordT vals [4];
        startProgram();
        for (int k = 0; k < 4; k++) begin
            vals[k] = $urandom();
            emitConst(1, vals[k]);
            emit(sw(1, 0, 32'h200 + k * 4));
            expectStore(32'h200 + k * 4, vals[k]);
        end
        for (int k = 0; k < 4; k++) begin
            emit(lw(2, 0, 32'h200 + k * 4));
            emit(sw(2, 0, 32'h280 + k * 4));
            expectStore(32'h280 + k * 4, vals[k]);
        end
        emit(addi(0, 0, 32'h123)); // dropped by x0
        emit(sw(0, 0, 32'h2c0));
        emit(lw(0, 0, 32'h200));
        emit(sw(0, 0, 32'h2c4));
        emit(addi(4, 0, -5));
        emit(sw(4, 0, 32'h2c8));
        expectStore(32'h2c0, '0);
        expectStore(32'h2c4, '0);
        expectStore(32'h2c8, 32'hffff_fffb);
        runProgram();
    endtask

    task automatic branchPaths();
        wordT lhs [4];
        wordT rhs [4];
        int   f3s [3];
        int   slot;
        logic taken;
        startProgram();
        lhs  = '{32'd5, 32'd5, 32'hffff_fffd, 32'd7};
        rhs  = '{32'd5, 32'd9, 32'd4, 32'd2};
        f3s  = '{0, 1, 4}; // beq, bne, blt
        slot = 0;
        for (int p = 0; p < 4; p++) begin
            emitConst(1, lhs[p]);
            emitConst(2, rhs[p]);
            for (int k = 0; k < 3; k++) begin
                case (k)
                    0: taken = lhs[p] == rhs[p];
                    1: taken = lhs[p] != rhs[p];
                    default: taken = $signed(lhs[p]) < $signed(rhs[p]);
                endcase
                emit(branch(f3s[k], 1, 2, 16));
                emit(addi(9, 0, 32'h400 + slot * 2)); // not-taken marker
                emit(sw(9, 0, 32'h300 + slot * 4));
                emit(jal(0, 12));
                emit(addi(9, 0, 32'h401 + slot * 2)); // taken marker
                emit(sw(9, 0, 32'h300 + slot * 4));
                expectStore(32'h300 + slot * 4, 32'h400 + slot * 2 + (taken ? 1 : 0));
                slot++;
            end
        end
        runProgram();
    endtask

    task automatic jumpsAndUpper();
        addrT at;
        wordT upper;
        startProgram();
        upper = $urandom() & 32'hffff_f000;
        emit(lui(3, upper));
        emit(sw(3, 0, 32'h380));
        expectStore(32'h380, upper);
        at = curAddr();
        emit(auipc(4, upper));
        emit(sw(4, 0, 32'h384));
        expectStore(32'h384, at + upper);
        at = curAddr();
        emit(jal(5, 12));
        emit(addi(9, 0, 32'h7ff)); // skipped
        emit(sw(9, 0, 32'h388));
        emit(sw(5, 0, 32'h38c));
        expectStore(32'h38c, at + 4);
        at = curAddr();
        emit(addi(6, 0, at + 12));
        emit(jalr(7, 6, 4)); // lands at + 16
        emit(addi(9, 0, 32'h7ff));
        emit(sw(9, 0, 32'h390));
        emit(sw(7, 0, 32'h394));
        expectStore(32'h394, at + 8);
        runProgram();
    endtask

    task automatic unknownNoop();
        startProgram();
        emit(addi(10, 0, 32'h55));
        emit(32'hffff_ffff);
        emit(rOp(1, 0, 10, 10, 10));                      // mul is not kept
        emit(iOp(7'b0000011, 0, 10, 0, 32'h200));         // lb
        emit(iOp(7'b0010011, 2, 10, 0, 1));               // slti
        emit({7'd0, 5'd10, 5'd0, 3'b001, 5'h10, 7'h23}); // sh
        emit(branch(3'b111, 0, 0, 32'h40));               // bgeu would be taken
        emit(sw(10, 0, 32'h3c0));
        expectStore(32'h3c0, 32'h55);
        runProgram();
    endtask

    initial begin
        reset       = 1'b1;
        errors      = 0;
        progIdx     = 0;
        resetStores = 0;
        void'($urandom(32'habdfc340));
        for (int i = 0; i < memWords; i++) begin
            dataMem[i]  <= (wordT'(i) * 32'h0101_0101) ^ 32'h5a5a_0000;
            instrMem[i] = addi(0, 0, 0);
        end
        arithOps();
        loadStoreCopies();
        branchPaths();
        jumpsAndUpper();
        unknownNoop();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- hw/riscvCore.sv
`timescale 1ns/1ps

module riscvCore #(
    parameter corePkg::addrT resetAddr = '0
) (
    input  logic          clk,
    input  logic          reset,
    output corePkg::addrT pc,
    input  isaPkg::instrT instr,
    output logic          memWe,
    output corePkg::addrT memAddr,
    output corePkg::wordT memWdata,
    input  corePkg::wordT memRdata
);
    import isaPkg::*;
    import corePkg::*;

    ctrlIf ctrlBus ();

    wordT imm;
    wordT rs1Data;
    wordT rs2Data;
    wordT aluResult;
    wordT wbData;
    logic zero;
    addrT pcPlus4;

    instrDecoder iDecoder (
        .instr (instr),
        .ctrl  (ctrlBus.decoder)
    );

    immGen iImmGen (
        .instr  (instr),
        .immFmt (ctrlBus.immFmt),
        .imm    (imm)
    );

    regFile iRegFile (
        .clk      (clk),
        .reset    (reset),
        .rs1Idx   (rs1Of(instr)),
        .rs2Idx   (rs2Of(instr)),
        .rdIdx    (rdOf(instr)),
        .wbData   (wbData),
        .regWrite (ctrlBus.regWrite),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    aluStage iAlu (
        .ctrl      (ctrlBus.exec),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .imm       (imm),
        .pc        (pc),
        .aluResult (aluResult),
        .zero      (zero)
    );

    pcUnit #(
        .resetAddr (resetAddr)
    ) iPc (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrlBus.flow),
        .imm       (imm),
        .aluResult (aluResult),
        .zero      (zero),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    always_comb begin
        case (ctrlBus.resultSel)
            resMem:     wbData = memRdata;
            resPcPlus4: wbData = pcPlus4; // link address
            default:    wbData = aluResult;
        endcase
    end

    assign memAddr  = aluResult;
    assign memWdata = rs2Data;
    assign memWe    = ctrlBus.memWrite;

endmodule

//--- hw/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
    parameter corePkg::addrT resetAddr = '0
) (
    input  logic          clk,
    input  logic          reset,
    ctrlIf.flow           ctrl,
    input  corePkg::wordT imm,
    input  corePkg::wordT aluResult,
    input  logic          zero,
    output corePkg::addrT pc,
    output corePkg::addrT pcPlus4
);
    import corePkg::*;

    logic taken;
    addrT target;
    addrT nextPc;

    assign pcPlus4 = pc + addrT'(4);

    always_comb begin
        case (ctrl.branchKind)
            brEq:    taken = zero;
            brNe:    taken = !zero;
            brLt:    taken = aluResult[0]; // slt result
            brJal:   taken = 1'b1;
            brJalr:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr keeps bit 0 of rs1+imm
    assign target = (ctrl.branchKind == brJalr) ? aluResult : pc + imm;
    assign nextPc = taken ? target : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetAddr;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- hw/aluStage.sv
`timescale 1ns/1ps

module aluStage (
    ctrlIf.exec           ctrl,
    input  corePkg::wordT rs1Data,
    input  corePkg::wordT rs2Data,
    input  corePkg::wordT imm,
    input  corePkg::addrT pc,
    output corePkg::wordT aluResult,
    output logic          zero
);
    import corePkg::*;

    wordT opA;
    wordT opB;
    logic lessThan;

    assign opA = ctrl.srcAPc ? pc : rs1Data; // auipc uses pc
    assign opB = ctrl.srcBImm ? imm : rs2Data;

    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluSlt:   aluResult = {{(xlenWidth-1){1'b0}}, lessThan};
            aluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  isaPkg::regIdxT  rs1Idx,
    input  isaPkg::regIdxT  rs2Idx,
    input  isaPkg::regIdxT  rdIdx,
    input  corePkg::wordT   wbData,
    input  logic            regWrite,
    output corePkg::wordT   rs1Data,
    output corePkg::wordT   rs2Data
);
    import corePkg::*;

    wordT regs [32]; // entry 0 never written

    always_ff @(posedge clk) begin
        if (!reset && regWrite && rdIdx != '0) begin
            regs[rdIdx] <= wbData;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
    assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

//--- hw/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  isaPkg::instrT   instr,
    input  corePkg::immFmtT immFmt,
    output corePkg::wordT   imm
);
    import corePkg::*;

    always_comb begin
        case (immFmt)
            immI: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            immS: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            immU: begin
                imm = {instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and no-op
            end
        endcase
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  isaPkg::instrT instr,
    ctrlIf.decoder        ctrl
);
    import isaPkg::*;
    import corePkg::*;

    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;

    assign opcode = opcodeOf(instr);
    assign funct3 = funct3Of(instr);
    assign funct7 = funct7Of(instr);

    always_comb begin
        // no-op unless a kept encoding matches below
        ctrl.immFmt     = immNone;
        ctrl.aluOp      = aluAdd;
        ctrl.srcBImm    = 1'b0;
        ctrl.srcAPc     = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.resultSel  = resAlu;
        ctrl.branchKind = brNone;

        case (opcode)
            opLoad: begin
                if (funct3 == f3Lw) begin
                    ctrl.immFmt    = immI;
                    ctrl.srcBImm   = 1'b1;
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSel = resMem;
                end
            end
            opOpImm: begin
                if (funct3 == f3Addi) begin
                    ctrl.immFmt   = immI;
                    ctrl.srcBImm  = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
            end
            opStore: begin
                if (funct3 == f3Sw) begin
                    ctrl.immFmt   = immS;
                    ctrl.srcBImm  = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
            end
            opOp: begin
                if (funct7 == f7Base) begin
                    case (funct3)
                        f3AddSub: begin
                            ctrl.aluOp    = aluAdd;
                            ctrl.regWrite = 1'b1;
                        end
                        f3Slt: begin
                            ctrl.aluOp    = aluSlt;
                            ctrl.regWrite = 1'b1;
                        end
                        f3And: begin
                            ctrl.aluOp    = aluAnd;
                            ctrl.regWrite = 1'b1;
                        end
                        default: ;
                    endcase
                end else if (funct7 == f7Sub && funct3 == f3AddSub) begin
                    ctrl.aluOp    = aluSub;
                    ctrl.regWrite = 1'b1;
                end
            end
            opBranch: begin
                case (funct3)
                    f3Beq: begin
                        ctrl.immFmt     = immB;
                        ctrl.aluOp      = aluSub; // zero flag on equal
                        ctrl.branchKind = brEq;
                    end
                    f3Bne: begin
                        ctrl.immFmt     = immB;
                        ctrl.aluOp      = aluSub;
                        ctrl.branchKind = brNe;
                    end
                    f3Blt: begin
                        ctrl.immFmt     = immB;
                        ctrl.aluOp      = aluSlt; // bit 0 decides
                        ctrl.branchKind = brLt;
                    end
                    default: ;
                endcase
            end
            opJalr: begin
                ctrl.immFmt     = immI;
                ctrl.srcBImm    = 1'b1; // target is rs1+imm
                ctrl.regWrite   = 1'b1;
                ctrl.resultSel  = resPcPlus4;
                ctrl.branchKind = brJalr;
            end
            opJal: begin
                ctrl.immFmt     = immJ;
                ctrl.regWrite   = 1'b1;
                ctrl.resultSel  = resPcPlus4;
                ctrl.branchKind = brJal;
            end
            opLui: begin
                ctrl.immFmt   = immU;
                ctrl.aluOp    = aluPassB;
                ctrl.srcBImm  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opAuipc: begin
                ctrl.immFmt   = immU;
                ctrl.srcAPc   = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import corePkg::*;

    immFmtT     immFmt;
    aluOpT      aluOp;
    logic       srcBImm; // B operand from immediate
    logic       srcAPc;  // A operand from pc
    logic       memWrite;
    logic       regWrite;
    resultSelT  resultSel;
    branchKindT branchKind;

    modport decoder (
        output immFmt, aluOp, srcBImm, srcAPc,
        output memWrite, regWrite, resultSel, branchKind
    );

    modport exec (
        input aluOp, srcBImm, srcAPc
    );

    modport flow (
        input branchKind
    );

    modport writeback (
        input regWrite, memWrite, resultSel, immFmt
    );

endinterface

//--- hw/corePkg.sv
package corePkg;

    localparam int xlenWidth = 32;

    typedef logic [xlenWidth-1:0] wordT;
    typedef logic [xlenWidth-1:0] addrT;

    typedef logic [2:0] aluOpT;
    localparam aluOpT aluAdd   = 3'd0;
    localparam aluOpT aluSub   = 3'd1;
    localparam aluOpT aluAnd   = 3'd2;
    localparam aluOpT aluSlt   = 3'd3; // signed compare
    localparam aluOpT aluPassB = 3'd6; // lui

    typedef logic [2:0] immFmtT;
    localparam immFmtT immNone = 3'd0;
    localparam immFmtT immI    = 3'd1;
    localparam immFmtT immS    = 3'd2;
    localparam immFmtT immB    = 3'd3;
    localparam immFmtT immU    = 3'd4;
    localparam immFmtT immJ    = 3'd5;

    typedef logic [2:0] branchKindT;
    localparam branchKindT brNone = 3'd0;
    localparam branchKindT brEq   = 3'd1;
    localparam branchKindT brNe   = 3'd2;
    localparam branchKindT brLt   = 3'd3;
    localparam branchKindT brJal  = 3'd4;
    localparam branchKindT brJalr = 3'd5;

    typedef logic [1:0] resultSelT;
    localparam resultSelT resAlu     = 2'd0;
    localparam resultSelT resMem     = 2'd1;
    localparam resultSelT resPcPlus4 = 2'd2; // link value for jal/jalr

endpackage

//--- hw/isaPkg.sv
package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;

    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opOpImm  = 7'b0010011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opOp     = 7'b0110011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;

    localparam funct3T f3Lw     = 3'b010;
    localparam funct3T f3Sw     = 3'b010;
    localparam funct3T f3Addi   = 3'b000;
    localparam funct3T f3AddSub = 3'b000; // add and sub share funct3
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3And    = 3'b111;
    localparam funct3T f3Beq    = 3'b000;
    localparam funct3T f3Bne    = 3'b001;
    localparam funct3T f3Blt    = 3'b100;

    localparam funct7T f7Base   = 7'b0000000;
    localparam funct7T f7Sub    = 7'b0100000;

    // field positions of the base instruction formats
    function automatic opcodeT opcodeOf(instrT instr);
        return instr[6:0];
    endfunction

    function automatic regIdxT rdOf(instrT instr);
        return instr[11:7];
    endfunction

    function automatic funct3T funct3Of(instrT instr);
        return instr[14:12];
    endfunction

    function automatic regIdxT rs1Of(instrT instr);
        return instr[19:15];
    endfunction

    function automatic regIdxT rs2Of(instrT instr);
        return instr[24:20];
    endfunction

    function automatic funct7T funct7Of(instrT instr);
        return instr[31:25];
    endfunction

endpackage
